// File: Bender.yml
package:
  name: greenhouse_ctrl

sources:
  - files:
      - source/sensor_pkg.sv
      - source/config_pkg.sv
      - source/sample_if.sv
      - source/sensor_capture.sv
      - source/config_regs.sv
      - source/climate_channel.sv
      - source/sun_tracker.sv
      - source/actuator_driver.sv
      - source/greenhouse_ctrl.sv
  - target: test
    files:
      - testbench/tb_greenhouse_ctrl.sv

// File: compile.f
source/sensor_pkg.sv
source/config_pkg.sv
source/sample_if.sv
source/sensor_capture.sv
source/config_regs.sv
source/climate_channel.sv
source/sun_tracker.sv
source/actuator_driver.sv
source/greenhouse_ctrl.sv
testbench/tb_greenhouse_ctrl.sv

// File: source/actuator_driver.sv
`timescale 1ns/1ns

module actuator_driver (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [sensor_pkg::NUM_SOURCES-1:0] request,
	input  logic [sensor_pkg::NUM_SOURCES-1:0] heating,
	output logic                               window_open,
	output logic                               fan_on,
	output logic                               geothermal_on,
	output logic                               solarheater_on
);

	import sensor_pkg::*;

	logic ambient_cooling;

	// Window is open to cool, so heaters must not fight it
	assign ambient_cooling = request[SRC_AMBIENT] & ~heating[SRC_AMBIENT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			window_open    <= 1'b0;
			geothermal_on  <= 1'b0;
			solarheater_on <= 1'b0;
		end else begin
			window_open    <= request[SRC_AMBIENT];
			geothermal_on  <= request[SRC_GEOTHERMAL] &
				~(ambient_cooling & heating[SRC_GEOTHERMAL]);
			solarheater_on <= request[SRC_SOLAR] &
				~(ambient_cooling & heating[SRC_SOLAR]);
		end
	end

	assign fan_on = window_open;  // Fan runs with the window

endmodule

// File: source/climate_channel.sv
`timescale 1ns/1ns

module climate_channel (
	input  logic                 clk,
	input  logic                 rst_n,
	sample_if.consumer           smp,
	input  sensor_pkg::source_e  src,
	input  config_pkg::th_pair_t th,
	output logic                 request,
	output logic                 heating
);

	import sensor_pkg::*;

	celsius_t src_temp;
	logic     cool_case;
	logic     heat_case;

	assign src_temp = smp.source_temp[src];

	// Greenhouse too warm and this source can carry heat away
	assign cool_case = (smp.greenhouse > th.cooldown) && (src_temp < smp.greenhouse);

	// Greenhouse too cold and this source can bring heat in
	assign heat_case = (smp.greenhouse < th.heatup) && (src_temp > smp.greenhouse);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			request <= 1'b0;
			heating <= 1'b0;
		end else if (smp.strobe) begin
			request <= cool_case | heat_case;
			heating <= heat_case;  // Read by the interlock
		end
	end

endmodule

// File: source/config_pkg.sv
package config_pkg;

	import sensor_pkg::*;

	// ##################################################################
	// Register map
	// ##################################################################

	typedef logic [1:0] cfg_addr_t;

	localparam cfg_addr_t CFG_LUX_TH  = 2'd0;  // Tracker threshold
	localparam cfg_addr_t CFG_CH_BASE = 2'd1;  // Channel k at base + k

	// ##################################################################
	// Threshold types
	// ##################################################################

	typedef struct packed {
		celsius_t cooldown;  // High byte
		celsius_t heatup;    // Low byte
	} th_pair_t;

	// One written word, decoded by address
	typedef union packed {
		lux_t     lux_th;
		th_pair_t pair;
	} cfg_word_u;

	// ##################################################################
	// Reset values
	// ##################################################################

	localparam lux_t     LUX_TH_RESET   = 16'd256;
	localparam celsius_t COOLDOWN_RESET = 8'sd30;
	localparam celsius_t HEATUP_RESET   = 8'sd15;

endpackage

// File: source/config_regs.sv
`timescale 1ns/1ns

module config_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cfg_write,
	input  config_pkg::cfg_addr_t cfg_addr,
	input  config_pkg::cfg_word_u cfg_data,
	output sensor_pkg::lux_t     lux_th,
	output config_pkg::th_pair_t ch_th [sensor_pkg::NUM_SOURCES]
);

	import sensor_pkg::*;
	import config_pkg::*;

	localparam th_pair_t TH_RESET = '{cooldown: COOLDOWN_RESET, heatup: HEATUP_RESET};

	// ##################################################################
	// Tracker threshold
	// ##################################################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lux_th <= LUX_TH_RESET;
		end else if (cfg_write && cfg_addr == CFG_LUX_TH) begin
			lux_th <= cfg_data.lux_th;  // Light view of the word
		end
	end

	// ##################################################################
	// Channel threshold pairs
	// ##################################################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < NUM_SOURCES; k++) begin
				ch_th[k] <= TH_RESET;
			end
		end else if (cfg_write) begin
			for (int k = 0; k < NUM_SOURCES; k++) begin
				if (cfg_addr == cfg_addr_t'(CFG_CH_BASE + k)) begin
					ch_th[k] <= cfg_data.pair;  // Pair view of the word
				end
			end
		end
	end

endmodule

// File: source/greenhouse_ctrl.sv
`timescale 1ns/1ns

module greenhouse_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  sample_valid,
	input  sensor_pkg::celsius_t  greenhouse_temp,
	input  sensor_pkg::celsius_t  ambient_temp,
	input  sensor_pkg::celsius_t  geothermal_temp,
	input  sensor_pkg::celsius_t  solar_temp,
	input  sensor_pkg::lux_t      n_lux,
	input  sensor_pkg::lux_t      e_lux,
	input  sensor_pkg::lux_t      s_lux,
	input  sensor_pkg::lux_t      w_lux,
	input  logic                  cfg_write,
	input  config_pkg::cfg_addr_t cfg_addr,
	input  config_pkg::cfg_word_u cfg_data,
	output logic                  window_open,
	output logic                  fan_on,
	output logic                  geothermal_on,
	output logic                  solarheater_on,
	output logic                  move_north,
	output logic                  move_east,
	output logic                  move_south,
	output logic                  move_west
);

	import sensor_pkg::*;
	import config_pkg::*;

	lux_t                   lux_th;
	th_pair_t               ch_th [NUM_SOURCES];
	logic [NUM_SOURCES-1:0] request;
	logic [NUM_SOURCES-1:0] heating;

	sample_if smp ();

	// ##################################################################
	// Capture and configuration
	// ##################################################################

	sensor_capture i_capture (
		.clk             (clk),
		.rst_n           (rst_n),
		.sample_valid    (sample_valid),
		.greenhouse_temp (greenhouse_temp),
		.ambient_temp    (ambient_temp),
		.geothermal_temp (geothermal_temp),
		.solar_temp      (solar_temp),
		.n_lux           (n_lux),
		.e_lux           (e_lux),
		.s_lux           (s_lux),
		.w_lux           (w_lux),
		.smp             (smp)
	);

	config_regs i_config (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_write (cfg_write),
		.cfg_addr  (cfg_addr),
		.cfg_data  (cfg_data),
		.lux_th    (lux_th),
		.ch_th     (ch_th)
	);

	// ##################################################################
	// Decision stages
	// ##################################################################

	for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_channel
		climate_channel i_channel (
			.clk     (clk),
			.rst_n   (rst_n),
			.smp     (smp),
			.src     (source_e'(i)),
			.th      (ch_th[i]),
			.request (request[i]),
			.heating (heating[i])
		);
	end

	sun_tracker i_tracker (
		.clk        (clk),
		.rst_n      (rst_n),
		.smp        (smp),
		.lux_th     (lux_th),
		.move_north (move_north),
		.move_east  (move_east),
		.move_south (move_south),
		.move_west  (move_west)
	);

	actuator_driver i_driver (
		.clk            (clk),
		.rst_n          (rst_n),
		.request        (request),
		.heating        (heating),
		.window_open    (window_open),
		.fan_on         (fan_on),
		.geothermal_on  (geothermal_on),
		.solarheater_on (solarheater_on)
	);

endmodule

// File: source/sample_if.sv
`timescale 1ns/1ns

interface sample_if;

	import sensor_pkg::*;

	logic     strobe;                    // One cycle per new snapshot
	celsius_t greenhouse;
	celsius_t source_temp [NUM_SOURCES]; // By source_e
	lux_t     lux [NUM_DIRS];            // N, E, S, W

	modport producer (
		output strobe,
		output greenhouse,
		output source_temp,
		output lux
	);

	modport consumer (
		input strobe,
		input greenhouse,
		input source_temp,
		input lux
	);

endinterface

// File: source/sensor_capture.sv
`timescale 1ns/1ns

module sensor_capture (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               sample_valid,
	input  sensor_pkg::celsius_t greenhouse_temp,
	input  sensor_pkg::celsius_t ambient_temp,
	input  sensor_pkg::celsius_t geothermal_temp,
	input  sensor_pkg::celsius_t solar_temp,
	input  sensor_pkg::lux_t   n_lux,
	input  sensor_pkg::lux_t   e_lux,
	input  sensor_pkg::lux_t   s_lux,
	input  sensor_pkg::lux_t   w_lux,
	sample_if.producer         smp
);

	import sensor_pkg::*;

	// Strobe follows the capture edge by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp.strobe <= 1'b0;
		end else begin
			smp.strobe <= sample_valid;
		end
	end

	// Snapshot holds until the next sample_valid
	always_ff @(posedge clk) begin
		if (sample_valid) begin
			smp.greenhouse                  <= greenhouse_temp;
			smp.source_temp[SRC_AMBIENT]    <= ambient_temp;
			smp.source_temp[SRC_GEOTHERMAL] <= geothermal_temp;
			smp.source_temp[SRC_SOLAR]      <= solar_temp;
			smp.lux[DIR_NORTH]              <= n_lux;
			smp.lux[DIR_EAST]               <= e_lux;
			smp.lux[DIR_SOUTH]              <= s_lux;
			smp.lux[DIR_WEST]               <= w_lux;
		end
	end

endmodule

// File: source/sensor_pkg.sv
package sensor_pkg;

	// ##################################################################
	// Sensor readings
	// ##################################################################

	typedef logic signed [7:0] celsius_t;  // Whole degrees C
	typedef logic [15:0] lux_t;            // One light sensor

	// ##################################################################
	// Climate sources and light directions
	// ##################################################################

	localparam int NUM_SOURCES = 3;
	localparam int NUM_DIRS    = 4;

	typedef enum logic [1:0] {
		SRC_AMBIENT    = 2'd0,
		SRC_GEOTHERMAL = 2'd1,
		SRC_SOLAR      = 2'd2
	} source_e;

	// Light sensor slots in the snapshot
	localparam int DIR_NORTH = 0;
	localparam int DIR_EAST  = 1;
	localparam int DIR_SOUTH = 2;
	localparam int DIR_WEST  = 3;

endpackage

// File: source/sun_tracker.sv
`timescale 1ns/1ns

module sun_tracker (
	input  logic             clk,
	input  logic             rst_n,
	sample_if.consumer       smp,
	input  sensor_pkg::lux_t lux_th,
	output logic             move_north,
	output logic             move_east,
	output logic             move_south,
	output logic             move_west
);

	import sensor_pkg::*;

	// Bit 1 moves toward a, bit 0 toward b
	function automatic logic [1:0] axis_move(lux_t a, lux_t b, lux_t th);
		logic [1:0] mv;
		mv = 2'b00;
		if (a > b && (a - b) > th) begin
			mv = 2'b10;
		end else if (b > a && (b - a) > th) begin
			mv = 2'b01;
		end
		return mv;
	endfunction

	logic [1:0] ns_move;
	logic [1:0] ew_move;

	assign ns_move = axis_move(smp.lux[DIR_NORTH], smp.lux[DIR_SOUTH], lux_th);
	assign ew_move = axis_move(smp.lux[DIR_EAST], smp.lux[DIR_WEST], lux_th);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			move_north <= 1'b0;
			move_south <= 1'b0;
			move_east  <= 1'b0;
			move_west  <= 1'b0;
		end else if (smp.strobe) begin
			{move_north, move_south} <= ns_move;
			{move_east, move_west}   <= ew_move;
		end
	end

endmodule

// File: testbench/tb_greenhouse_ctrl.sv
`timescale 1ns/1ns

module tb_greenhouse_ctrl;

	import sensor_pkg::*;
	import config_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY  = 2;
	localparam int TABLE_ROWS   = 12;
	localparam int NUM_RANDOM   = 40;
	localparam int WATCHDOG_NS  =
		(RESET_CYCLES + 2 * (TABLE_ROWS + NUM_RANDOM + 1) * 4) * CLK_PERIOD;

	typedef struct packed {
		logic              wr;
		logic [1:0]        addr;
		logic [15:0]       data;
		logic signed [7:0] gh;
		logic signed [7:0] amb;
		logic signed [7:0] geo;
		logic signed [7:0] sol;
		logic [15:0]       n;
		logic [15:0]       e;
		logic [15:0]       s;
		logic [15:0]       w;
		logic [7:0]        exp;  // window, fan, geo, solar, N, E, S, W
	} row_t;

	logic      clk;
	logic      rst_n;
	logic      sample_valid;
	celsius_t  greenhouse_temp;
	celsius_t  ambient_temp;
	celsius_t  geothermal_temp;
	celsius_t  solar_temp;
	lux_t      n_lux;
	lux_t      e_lux;
	lux_t      s_lux;
	lux_t      w_lux;
	logic      cfg_write;
	cfg_addr_t cfg_addr;
	cfg_word_u cfg_data;
	logic      window_open;
	logic      fan_on;
	logic      geothermal_on;
	logic      solarheater_on;
	logic      move_north;
	logic      move_east;
	logic      move_south;
	logic      move_west;

	row_t        table_rows [TABLE_ROWS];
	int          error_count = 0;
	int          check_count = 0;
	int unsigned rng_state   = 27064;

	// Threshold copy kept in step with every write the testbench issues
	int sh_lux;
	int sh_cd [NUM_SOURCES];
	int sh_hu [NUM_SOURCES];

	greenhouse_ctrl i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	// ##################################################################
	// Helpers
	// ##################################################################

	function automatic int next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return int'(rng_state >> 1);
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + next_rand() % (hi - lo + 1);
	endfunction

	task automatic step();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic check_outputs(input logic [7:0] exp);
		check_value("window_open", window_open, exp[7]);
		check_value("fan_on", fan_on, exp[6]);
		check_value("geothermal_on", geothermal_on, exp[5]);
		check_value("solarheater_on", solarheater_on, exp[4]);
		check_value("move_north", move_north, exp[3]);
		check_value("move_east", move_east, exp[2]);
		check_value("move_south", move_south, exp[1]);
		check_value("move_west", move_west, exp[0]);
	endtask

	task automatic set_row(input int idx, input logic wr, input logic [1:0] addr,
			input logic [15:0] data, input int gh, input int amb, input int geo,
			input int sol, input int n, input int e, input int s, input int w,
			input logic [7:0] exp);
		row_t r;
		r = '{wr, addr, data, gh[7:0], amb[7:0], geo[7:0], sol[7:0],
			n[15:0], e[15:0], s[15:0], w[15:0], exp};
		table_rows[idx] = r;
	endtask

	// ##################################################################
	// Model of the control rules
	// ##################################################################

	task automatic update_shadow(input row_t r);
		if (r.wr) begin
			if (r.addr == 2'd0) begin
				sh_lux = int'(r.data);
			end else begin
				sh_cd[r.addr - 1] = int'($signed(r.data[15:8]));  // Cooldown in high byte
				sh_hu[r.addr - 1] = int'($signed(r.data[7:0]));
			end
		end
	endtask

	function automatic logic [7:0] model_outputs(input row_t r);
		int         gh;
		int         src [NUM_SOURCES];
		logic [2:0] cool;
		logic [2:0] heat;
		logic [7:0] o;
		int         n;
		int         e;
		int         s;
		int         w;
		gh     = int'($signed(r.gh));
		src[0] = int'($signed(r.amb));
		src[1] = int'($signed(r.geo));
		src[2] = int'($signed(r.sol));
		for (int k = 0; k < NUM_SOURCES; k++) begin
			cool[k] = (gh > sh_cd[k]) && (src[k] < gh);
			heat[k] = (gh < sh_hu[k]) && (src[k] > gh);
		end
		n    = int'(r.n);
		e    = int'(r.e);
		s    = int'(r.s);
		w    = int'(r.w);
		o[7] = cool[0] | heat[0];
		o[6] = o[7];
		o[5] = (cool[1] | heat[1]) && !(cool[0] && heat[1]);  // No heating against the window
		o[4] = (cool[2] | heat[2]) && !(cool[0] && heat[2]);
		o[3] = (n - s) > sh_lux;
		o[2] = (e - w) > sh_lux;
		o[1] = (s - n) > sh_lux;
		o[0] = (w - e) > sh_lux;
		return o;
	endfunction

	// One configuration cycle, one sample pulse, three cycles of settling
	task automatic run_row(input row_t r, input bit from_model);
		update_shadow(r);
		if (from_model) begin
			r.exp = model_outputs(r);
		end
		step();
		cfg_write = r.wr;
		cfg_addr  = r.addr;
		cfg_data  = r.data;
		step();
		cfg_write       = 1'b0;
		sample_valid    = 1'b1;
		greenhouse_temp = r.gh;
		ambient_temp    = r.amb;
		geothermal_temp = r.geo;
		solar_temp      = r.sol;
		n_lux           = r.n;
		e_lux           = r.e;
		s_lux           = r.s;
		w_lux           = r.w;
		step();
		sample_valid = 1'b0;
		repeat (3) step();
		check_outputs(r.exp);
	endtask

	// ##################################################################
	// Stimulus
	// ##################################################################

	initial begin
		row_t r;
		rst_n           = 1'b0;
		sample_valid    = 1'b0;
		greenhouse_temp = '0;
		ambient_temp    = '0;
		geothermal_temp = '0;
		solar_temp      = '0;
		n_lux           = '0;
		e_lux           = '0;
		s_lux           = '0;
		w_lux           = '0;
		cfg_write       = 1'b0;
		cfg_addr        = '0;
		cfg_data        = '0;
		sh_lux          = int'(LUX_TH_RESET);
		for (int k = 0; k < NUM_SOURCES; k++) begin
			sh_cd[k] = int'(COOLDOWN_RESET);
			sh_hu[k] = int'(HEATUP_RESET);
		end

		set_row(0, 0, 2'd0, 16'h0000, 35, 20, 40, 40, 500, 500, 500, 500, 8'b1100_0000);
		set_row(1, 0, 2'd0, 16'h0000, 10, 5, 14, 5, 500, 500, 500, 500, 8'b0010_0000);
		set_row(2, 0, 2'd0, 16'h0000, 22, 0, 30, 50, 500, 500, 500, 500, 8'b0000_0000);
		set_row(3, 1, 2'd3, 16'h1E28, 35, 20, 40, 50, 500, 500, 500, 500, 8'b1100_0000);
		set_row(4, 0, 2'd0, 16'h0000, 35, 40, 40, 50, 500, 500, 500, 500, 8'b0001_0000);
		set_row(5, 1, 2'd1, 16'h240F, 35, 20, 40, 50, 500, 500, 500, 500, 8'b0001_0000);
		set_row(6, 0, 2'd1, 16'h140F, 35, 20, 40, 50, 500, 500, 500, 500, 8'b0001_0000);
		set_row(7, 0, 2'd0, 16'h0000, 22, 0, 30, 10, 900, 500, 100, 500, 8'b0000_1000);
		set_row(8, 0, 2'd0, 16'h0000, 22, 0, 30, 10, 400, 300, 300, 500, 8'b0000_0000);
		set_row(9, 0, 2'd0, 16'h0000, 22, 0, 30, 10, 500, 100, 500, 700, 8'b0000_0001);
		set_row(10, 1, 2'd0, 16'd1000, 22, 0, 30, 10, 500, 100, 500, 700, 8'b0000_0000);
		set_row(11, 0, 2'd0, 16'h0000, 22, 0, 30, 10, 500, 1800, 2000, 100, 8'b0000_0110);

		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		check_outputs(8'b0000_0000);  // Idle after reset
		repeat (2) step();
		check_outputs(8'b0000_0000);

		for (int i = 0; i < TABLE_ROWS; i++) begin
			run_row(table_rows[i], 1'b0);
		end

		for (int i = 0; i < NUM_RANDOM; i++) begin
			r      = '0;
			r.wr   = rand_range(0, 1);
			r.addr = rand_range(0, 3);
			if (r.addr == 2'd0) begin
				r.data = rand_range(0, 1023);
			end else begin
				r.data = {8'(rand_range(15, 40)), 8'(rand_range(0, 30))};
			end
			r.gh  = rand_range(-10, 50);
			r.amb = rand_range(-10, 50);
			r.geo = rand_range(-10, 50);
			r.sol = rand_range(-10, 50);
			r.n   = rand_range(0, 2047);
			r.e   = rand_range(0, 2047);
			r.s   = rand_range(0, 2047);
			r.w   = rand_range(0, 2047);
			run_row(r, 1'b1);
		end

		$display("Finished: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
